//--- rtl/game_pkg.sv
`default_nettype none

package game_pkg;

   typedef logic signed [10:0] coord_t;        // screen coordinate, may go negative

   typedef struct packed {
      coord_t x;
      coord_t y;
   } pixel_pos_t;                               // current spot on screen

   typedef struct packed {
      coord_t x;                                // left column
      coord_t y;                                // top line
   } sprite_pos_t;

   typedef struct packed {
      logic up;
      logic down;
      logic left;
      logic right;
   } move_t;                                    // held direction levels

   typedef logic [2:0] sprite_num_t;            // palette selector
   typedef logic [7:0] color8_t;                // rgb332

   typedef struct packed {
      logic    hit;                             // spot inside sprite
      color8_t color;
   } layer_t;

   typedef struct packed {
      logic [9:0] r;
      logic [9:0] g;
      logic [9:0] b;
   } rgb_t;                                     // dac channels

   typedef struct packed {
      logic hs;                                 // active low
      logic vs;                                 // active low
      logic active;                             // visible area
   } video_sync_t;

   typedef enum logic [1:0] {
      PH_ACTIVE,
      PH_FRONT,
      PH_SYNC,
      PH_BACK
   } timing_phase_e;

   // rgb332 sprite colours
   localparam color8_t SPRITE_PALETTE [8] = '{
      8'hE0, 8'h1C, 8'h03, 8'hFC,               // red green blue yellow
      8'hE3, 8'h1F, 8'hFF, 8'h92                // magenta cyan white grey
   };

   localparam int MAX_PLAYERS = 4;

   // reset corners, players 0 and 1 overlap on purpose
   localparam sprite_pos_t PLAYER_START [MAX_PLAYERS] = '{
      '{x: 11'sd4,  y: 11'sd4},
      '{x: 11'sd6,  y: 11'sd6},
      '{x: 11'sd20, y: 11'sd4},
      '{x: 11'sd20, y: 11'sd14}
   };

endpackage

`default_nettype wire

//--- rtl/game_video_top.sv
`timescale 1ns/1ps
`default_nettype none

module game_video_top #(
   parameter int H_ACTIVE    = 640,
   parameter int H_FRONT     = 16,
   parameter int H_SYNC      = 96,
   parameter int H_BACK      = 48,
   parameter int V_ACTIVE    = 480,
   parameter int V_FRONT     = 10,
   parameter int V_SYNC      = 2,
   parameter int V_BACK      = 33,
   parameter int SPRITE_SIZE = 16,
   parameter int MOVE_STEP   = 2,
   parameter int NUM_PLAYERS = 2               // up to MAX_PLAYERS
) (
   input  logic                  clock_50,
   input  logic                  rst_n,
   input  game_pkg::move_t       player_move [NUM_PLAYERS],
   input  game_pkg::sprite_num_t sprite_num  [NUM_PLAYERS],
   output game_pkg::rgb_t        vga_rgb,
   output logic                  vga_hs,
   output logic                  vga_vs,
   output logic                  vga_blank
);
   import game_pkg::*;

   pixel_pos_t  spot;                           // from timing
   video_sync_t spot_sync;
   logic        frame_end;
   sprite_pos_t player_pos [NUM_PLAYERS];       // sprite corners
   layer_t      layers     [NUM_PLAYERS];       // registered hits

   vga_timing #(
      .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
      .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
   ) vga_timing_i (
      .clock_50 (clock_50),
      .rst_n    (rst_n),
      .spot     (spot),
      .spot_sync(spot_sync),
      .frame_end(frame_end)
   );

   position_ctrl #(
      .NUM_PLAYERS(NUM_PLAYERS), .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE),
      .SPRITE_SIZE(SPRITE_SIZE), .MOVE_STEP(MOVE_STEP)
   ) position_ctrl_i (
      .clock_50   (clock_50),
      .rst_n      (rst_n),
      .frame_end  (frame_end),
      .player_move(player_move),
      .player_pos (player_pos)
   );

   for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_sprite
      sprite_layer #(.SPRITE_SIZE(SPRITE_SIZE)) sprite_layer_i (
         .clock_50  (clock_50),
         .rst_n     (rst_n),
         .spot      (spot),
         .sprite_pos(player_pos[p]),
         .sprite_num(sprite_num[p]),
         .layer     (layers[p])
      );
   end

   pixel_mixer #(.NUM_PLAYERS(NUM_PLAYERS)) pixel_mixer_i (
      .clock_50 (clock_50),
      .rst_n    (rst_n),
      .spot     (spot),
      .spot_sync(spot_sync),
      .layers   (layers),
      .vga_rgb  (vga_rgb),
      .vga_hs   (vga_hs),
      .vga_vs   (vga_vs),
      .vga_blank(vga_blank)
   );

endmodule

`default_nettype wire

//--- rtl/pixel_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer #(
   parameter int NUM_PLAYERS = 2
) (
   input  logic                  clock_50,
   input  logic                  rst_n,
   input  game_pkg::pixel_pos_t  spot,
   input  game_pkg::video_sync_t spot_sync,
   input  game_pkg::layer_t      layers [NUM_PLAYERS],
   output game_pkg::rgb_t        vga_rgb,
   output logic                  vga_hs,
   output logic                  vga_vs,
   output logic                  vga_blank
);
   import game_pkg::*;

   localparam logic [7:0] BG_G = 8'h40;        // flat green
   localparam logic [7:0] BG_B = 8'h80;        // flat blue

   logic [7:0]  bg_r_q;                         // gradient, stage 1
   video_sync_t sync_q1;                        // sync, stage 1
   logic        win_hit;
   color8_t     win_color;
   logic [7:0]  r8;
   logic [7:0]  g8;
   logic [7:0]  b8;
   rgb_t        rgb_next;

   function automatic logic [7:0] widen3(input logic [2:0] c);
      return {c, c, c[2:1]};
   endfunction

   function automatic logic [7:0] widen2(input logic [1:0] c);
      return {c, c, c, c};
   endfunction

   function automatic logic [9:0] expand10(input logic [7:0] c);
      return {c, c[7:6]};                       // top bits fill the lsbs
   endfunction

   always_ff @(posedge clock_50) begin
      bg_r_q <= spot.x[7:0];                    // ramp across the line
   end

   always_ff @(posedge clock_50 or negedge rst_n) begin
      if (!rst_n) begin
         sync_q1 <= '{hs: 1'b1, vs: 1'b1, active: 1'b0};
      end else begin
         sync_q1 <= spot_sync;
      end
   end

   // lowest player number on top
   always_comb begin
      win_hit   = 1'b0;
      win_color = '0;
      for (int i = 0; i < NUM_PLAYERS; i++) begin
         if (!win_hit && layers[i].hit) begin
            win_hit   = 1'b1;
            win_color = layers[i].color;
         end
      end
   end

   assign r8 = win_hit ? widen3(win_color[7:5]) : bg_r_q;
   assign g8 = win_hit ? widen3(win_color[4:2]) : BG_G;
   assign b8 = win_hit ? widen2(win_color[1:0]) : BG_B;

   assign rgb_next.r = sync_q1.active ? expand10(r8) : '0;  // black in blanking
   assign rgb_next.g = sync_q1.active ? expand10(g8) : '0;
   assign rgb_next.b = sync_q1.active ? expand10(b8) : '0;

   always_ff @(posedge clock_50 or negedge rst_n) begin
      if (!rst_n) begin
         vga_rgb   <= '0;
         vga_hs    <= 1'b1;
         vga_vs    <= 1'b1;
         vga_blank <= 1'b0;
      end else begin
         vga_rgb   <= rgb_next;                 // two cycles after spot
         vga_hs    <= sync_q1.hs;
         vga_vs    <= sync_q1.vs;
         vga_blank <= sync_q1.active;           // high while visible
      end
   end

endmodule

`default_nettype wire

//--- rtl/position_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module position_ctrl #(
   parameter int NUM_PLAYERS = 2,
   parameter int H_ACTIVE    = 640,
   parameter int V_ACTIVE    = 480,
   parameter int SPRITE_SIZE = 16,
   parameter int MOVE_STEP   = 2
) (
   input  logic                  clock_50,
   input  logic                  rst_n,
   input  logic                  frame_end,
   input  game_pkg::move_t       player_move [NUM_PLAYERS],
   output game_pkg::sprite_pos_t player_pos  [NUM_PLAYERS]
);
   import game_pkg::*;

   localparam int X_MAX = H_ACTIVE - SPRITE_SIZE;  // rightmost legal corner
   localparam int Y_MAX = V_ACTIVE - SPRITE_SIZE;  // lowest legal corner

   move_t move_meta [NUM_PLAYERS];              // first sync stage
   move_t move_sync [NUM_PLAYERS];              // safe to use

   // one axis, step then clamp onto the screen
   function automatic coord_t step_axis(input coord_t pos, input logic dec,
                                        input logic inc, input int limit);
      int p;
      p = int'(pos);
      if (inc && !dec) begin
         p = p + MOVE_STEP;
      end else if (dec && !inc) begin
         p = p - MOVE_STEP;
      end
      if (p < 0) begin
         p = 0;
      end else if (p > limit) begin
         p = limit;
      end
      return coord_t'(p);
   endfunction

   always_ff @(posedge clock_50 or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_PLAYERS; i++) begin
            move_meta[i]  <= '0;
            move_sync[i]  <= '0;
            player_pos[i] <= PLAYER_START[i];
         end
      end else begin
         for (int i = 0; i < NUM_PLAYERS; i++) begin
            move_meta[i] <= player_move[i];     // levels are asynchronous
            move_sync[i] <= move_meta[i];
            if (frame_end) begin                // new corner from next frame on
               player_pos[i].x <= step_axis(player_pos[i].x, move_sync[i].left,
                                            move_sync[i].right, X_MAX);
               player_pos[i].y <= step_axis(player_pos[i].y, move_sync[i].up,
                                            move_sync[i].down, Y_MAX);
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/sprite_layer.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_layer #(
   parameter int SPRITE_SIZE = 16
) (
   input  logic                  clock_50,
   input  logic                  rst_n,
   input  game_pkg::pixel_pos_t  spot,
   input  game_pkg::sprite_pos_t sprite_pos,
   input  game_pkg::sprite_num_t sprite_num,
   output game_pkg::layer_t      layer
);
   import game_pkg::*;

   logic    in_x;                               // column inside square
   logic    in_y;                               // line inside square
   logic    hit_q;
   color8_t color_q;

   // half-open window [pos, pos + size)
   assign in_x = (spot.x >= sprite_pos.x) && (spot.x < sprite_pos.x + SPRITE_SIZE);
   assign in_y = (spot.y >= sprite_pos.y) && (spot.y < sprite_pos.y + SPRITE_SIZE);

   always_ff @(posedge clock_50 or negedge rst_n) begin
      if (!rst_n) begin
         hit_q <= 1'b0;
      end else begin
         hit_q <= in_x && in_y;
      end
   end

   always_ff @(posedge clock_50) begin
      color_q <= SPRITE_PALETTE[sprite_num];    // same stage as hit
   end

   assign layer.hit   = hit_q;
   assign layer.color = color_q;

endmodule

`default_nettype wire

//--- rtl/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
   parameter int H_ACTIVE = 640,
   parameter int H_FRONT  = 16,
   parameter int H_SYNC   = 96,
   parameter int H_BACK   = 48,
   parameter int V_ACTIVE = 480,
   parameter int V_FRONT  = 10,
   parameter int V_SYNC   = 2,
   parameter int V_BACK   = 33
) (
   input  logic                  clock_50,
   input  logic                  rst_n,
   output game_pkg::pixel_pos_t  spot,
   output game_pkg::video_sync_t spot_sync,
   output logic                  frame_end
);
   import game_pkg::*;

   timing_phase_e h_phase;                      // horizontal phase
   timing_phase_e v_phase;                      // vertical phase
   logic [10:0]   h_cnt;                        // count inside h phase
   logic [10:0]   v_cnt;                        // line count inside v phase
   logic [10:0]   h_end_cnt;
   logic [10:0]   v_end_cnt;
   logic          h_wrap;                       // last cycle of h phase
   logic          v_wrap;                       // last line of v phase
   logic          h_last;                       // end of line
   logic          v_last;                       // last line of frame

   // last count of a phase, given its four lengths
   function automatic logic [10:0] phase_end(input timing_phase_e ph, input int act,
                                             input int fp, input int sy, input int bp);
      case (ph)
         PH_ACTIVE: return 11'(act - 1);
         PH_FRONT:  return 11'(fp - 1);
         PH_SYNC:   return 11'(sy - 1);
         default:   return 11'(bp - 1);
      endcase
   endfunction

   function automatic timing_phase_e phase_next(input timing_phase_e ph);
      case (ph)
         PH_ACTIVE: return PH_FRONT;
         PH_FRONT:  return PH_SYNC;
         PH_SYNC:   return PH_BACK;
         default:   return PH_ACTIVE;
      endcase
   endfunction

   assign h_end_cnt = phase_end(h_phase, H_ACTIVE, H_FRONT, H_SYNC, H_BACK);
   assign v_end_cnt = phase_end(v_phase, V_ACTIVE, V_FRONT, V_SYNC, V_BACK);
   assign h_wrap    = (h_cnt == h_end_cnt);
   assign v_wrap    = (v_cnt == v_end_cnt);
   assign h_last    = h_wrap && (h_phase == PH_BACK);
   assign v_last    = v_wrap && (v_phase == PH_BACK);
   assign frame_end = h_last && v_last;         // one cycle per frame

   always_ff @(posedge clock_50 or negedge rst_n) begin
      if (!rst_n) begin
         h_cnt   <= '0;                         // first active pixel
         h_phase <= PH_ACTIVE;
         v_cnt   <= '0;
         v_phase <= PH_ACTIVE;
      end else begin
         if (h_wrap) begin
            h_cnt   <= '0;
            h_phase <= phase_next(h_phase);
         end else begin
            h_cnt <= h_cnt + 11'd1;
         end
         if (h_last) begin                      // lines step at end of line
            if (v_wrap) begin
               v_cnt   <= '0;
               v_phase <= phase_next(v_phase);
            end else begin
               v_cnt <= v_cnt + 11'd1;
            end
         end
      end
   end

   // coordinates only meaningful in the active area, -1 elsewhere
   assign spot.x = (h_phase == PH_ACTIVE) ? coord_t'(h_cnt) : coord_t'(-1);
   assign spot.y = (v_phase == PH_ACTIVE) ? coord_t'(v_cnt) : coord_t'(-1);

   assign spot_sync.hs     = (h_phase != PH_SYNC);
   assign spot_sync.vs     = (v_phase != PH_SYNC);
   assign spot_sync.active = (h_phase == PH_ACTIVE) && (v_phase == PH_ACTIVE);

endmodule

`default_nettype wire

//--- tb.f
rtl/game_pkg.sv
rtl/vga_timing.sv
rtl/position_ctrl.sv
rtl/sprite_layer.sv
rtl/pixel_mixer.sv
rtl/game_video_top.sv
tb/tb_clock_gen.sv
tb/tb_game_video.sv

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 10
) (
   output logic clock_50,
   output logic rst_n
);

   initial begin
      clock_50 = 1'b0;
      forever #(PERIOD_NS / 2) clock_50 = ~clock_50;  // free running
   end

   initial begin
      rst_n = 1'b0;                             // held low from time zero
      repeat (RESET_CYCLES) @(posedge clock_50);
      #1 rst_n = 1'b1;                          // released just after an edge
   end

endmodule

`default_nettype wire

//--- tb/tb_game_video.sv
`timescale 1ns/1ps
`default_nettype none

module tb_game_video;
   import game_pkg::*;

   localparam int H_ACTIVE     = 32;            // small frame for fast runs
   localparam int H_FRONT      = 2;
   localparam int H_SYNC       = 4;
   localparam int H_BACK       = 2;
   localparam int V_ACTIVE     = 24;
   localparam int V_FRONT      = 1;
   localparam int V_SYNC       = 2;
   localparam int V_BACK       = 1;
   localparam int SPRITE_SIZE  = 4;
   localparam int MOVE_STEP    = 2;
   localparam int NUM_PLAYERS  = 2;
   localparam int RESET_CYCLES = 10;
   localparam int DRIVE_DELAY  = 1;             // ns after rising edge
   localparam int FRAME_CYCLES = (H_ACTIVE + H_FRONT + H_SYNC + H_BACK) *
                                 (V_ACTIVE + V_FRONT + V_SYNC + V_BACK);

   typedef struct packed {
      move_t       [1:0] mv;                    // held levels per player
      sprite_num_t [1:0] num;
      logic        [7:0] frames;                // frames to run
      sprite_pos_t [1:0] exp_pos;               // corners after those frames
   } row_t;

   logic        clock_50;
   logic        rst_n;
   move_t       player_move [NUM_PLAYERS];
   sprite_num_t sprite_num  [NUM_PLAYERS];
   rgb_t        vga_rgb;
   logic        vga_hs;
   logic        vga_vs;
   logic        vga_blank;

   row_t        rows [$];
   string       names [$];
   string       cur_test      = "reset";
   int          total_frames  = 0;
   int          timeout_limit = 0;
   int          cycle_cnt     = 0;
   int          vs_falls      = 0;              // frames seen by tracker
   sprite_pos_t pos_model [NUM_PLAYERS];        // tracker's own corners
   int          x_cnt;
   int          y_cnt;
   int          hs_low;
   int          edge_x;
   int          edge_y;
   logic        prev_blank;
   logic        prev_hs;
   logic        prev_vs;
   logic        edge_found;

   tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(RESET_CYCLES)) tb_clock_gen_i (
      .clock_50(clock_50),
      .rst_n   (rst_n)
   );

   game_video_top #(
      .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
      .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
      .SPRITE_SIZE(SPRITE_SIZE), .MOVE_STEP(MOVE_STEP), .NUM_PLAYERS(NUM_PLAYERS)
   ) game_video_top_i (
      .clock_50   (clock_50),
      .rst_n      (rst_n),
      .player_move(player_move),
      .sprite_num (sprite_num),
      .vga_rgb    (vga_rgb),
      .vga_hs     (vga_hs),
      .vga_vs     (vga_vs),
      .vga_blank  (vga_blank)
   );

   task automatic check_rgb(input string what, input rgb_t exp, input rgb_t act);
      if (exp !== act) begin
         $display("Error: %s %s expected %h actual %h", cur_test, what, exp, act);
         $display("TEST FAIL");
         $fatal(1, "colour mismatch");
      end
   endtask

   task automatic check_coord(input string what, input coord_t exp, input coord_t act);
      if (exp !== act) begin
         $display("Error: %s %s expected %0d actual %0d", cur_test, what, exp, act);
         $display("TEST FAIL");
         $fatal(1, "coordinate mismatch");
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      if (exp !== act) begin
         $display("Error: %s %s expected %b actual %b", cur_test, what, exp, act);
         $display("TEST FAIL");
         $fatal(1, "flag mismatch");
      end
   endtask

   // rgb332 widened by bit repeat then 8 to 10 bits with the top two bits
   function automatic rgb_t sprite_rgb(input color8_t c);
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
      r = {c[7:5], c[7:5], c[7:6]};
      g = {c[4:2], c[4:2], c[4:3]};
      b = {4{c[1:0]}};
      return '{r: {r, r[7:6]}, g: {g, g[7:6]}, b: {b, b[7:6]}};
   endfunction

   function automatic rgb_t expected_pixel(input int x, input int y);
      logic [7:0] r;
      r = 8'(x);                                // gradient along the line
      for (int p = 0; p < NUM_PLAYERS; p++) begin
         if (x >= pos_model[p].x && x < pos_model[p].x + SPRITE_SIZE &&
             y >= pos_model[p].y && y < pos_model[p].y + SPRITE_SIZE) begin
            return sprite_rgb(SPRITE_PALETTE[sprite_num[p]]);  // lowest index wins
         end
      end
      return '{r: {r, r[7:6]}, g: 10'h101, b: 10'h202};
   endfunction

   function automatic coord_t next_coord(input coord_t cur, input logic dec,
                                         input logic inc, input int lim);
      int v;
      v = int'(cur);
      if (inc && !dec) v = v + MOVE_STEP;
      if (dec && !inc) v = v - MOVE_STEP;
      if (v < 0) v = 0;
      if (v > lim) v = lim;                     // clamp onto screen
      return coord_t'(v);
   endfunction

   task automatic add_row(input string name, input move_t m0, input move_t m1,
                          input sprite_num_t n0, input sprite_num_t n1, input int frames,
                          input int x0, input int y0, input int x1, input int y1);
      row_t r;
      r.mv      = {m1, m0};
      r.num     = {n1, n0};
      r.frames  = 8'(frames);
      r.exp_pos = {sprite_pos_t'{x: coord_t'(x1), y: coord_t'(y1)},
                   sprite_pos_t'{x: coord_t'(x0), y: coord_t'(y0)}};
      rows.push_back(r);
      names.push_back(name);
      total_frames += frames;
   endtask

   task automatic check_reset_outputs();
      check_flag("vga_hs", 1'b1, vga_hs);
      check_flag("vga_vs", 1'b1, vga_vs);
      check_flag("vga_blank", 1'b0, vga_blank);
      check_rgb("vga_rgb", '0, vga_rgb);
   endtask

   task automatic wait_vs_falls(input int target);
      while (vs_falls < target) @(posedge clock_50);
   endtask

   // pixel tracker samples at the falling edge where outputs are settled
   always @(negedge clock_50) begin
      if (!rst_n) begin
         x_cnt = 0;
         y_cnt = 0;
         hs_low = 0;
         prev_blank = 1'b0;
         prev_hs = 1'b1;
         prev_vs = 1'b1;
         edge_found = 1'b0;
         for (int p = 0; p < NUM_PLAYERS; p++) pos_model[p] = PLAYER_START[p];
      end else begin
         if (vga_blank) begin
            check_rgb($sformatf("pixel(%0d,%0d)", x_cnt, y_cnt),
                      expected_pixel(x_cnt, y_cnt), vga_rgb);
            if (!edge_found && vga_rgb == sprite_rgb(SPRITE_PALETTE[sprite_num[0]])) begin
               edge_found = 1'b1;               // top-left of player 0
               edge_x = x_cnt;
               edge_y = y_cnt;
            end
            x_cnt++;
         end else begin
            check_rgb("blanking", '0, vga_rgb);
         end
         if (prev_blank && !vga_blank) begin    // end of an active line
            check_coord("line_width", coord_t'(H_ACTIVE), coord_t'(x_cnt));
            x_cnt = 0;
            y_cnt++;
         end
         if (!vga_hs) hs_low++;
         if (vga_hs && !prev_hs) begin
            check_coord("hsync_width", coord_t'(H_SYNC), coord_t'(hs_low));
            hs_low = 0;
         end
         if (prev_vs && !vga_vs) begin          // active area of frame done
            check_coord("frame_lines", coord_t'(V_ACTIVE), coord_t'(y_cnt));
            if (sprite_num[0] != sprite_num[1]) begin  // colours tell sprites apart
               check_flag("p0_seen", 1'b1, edge_found);
               check_coord("p0_left", pos_model[0].x, coord_t'(edge_x));
               check_coord("p0_top", pos_model[0].y, coord_t'(edge_y));
            end
            y_cnt = 0;
            edge_found = 1'b0;
            vs_falls++;
         end
         if (!prev_vs && vga_vs) begin          // frame end steps the model
            for (int p = 0; p < NUM_PLAYERS; p++) begin
               pos_model[p].x = next_coord(pos_model[p].x, player_move[p].left,
                                           player_move[p].right, H_ACTIVE - SPRITE_SIZE);
               pos_model[p].y = next_coord(pos_model[p].y, player_move[p].up,
                                           player_move[p].down, V_ACTIVE - SPRITE_SIZE);
            end
         end
         prev_blank = vga_blank;
         prev_hs = vga_hs;
         prev_vs = vga_vs;
      end
   end

   always @(posedge clock_50) begin
      cycle_cnt++;
      if (timeout_limit > 0 && cycle_cnt > timeout_limit) begin
         $display("Timeout: test %s still running after %0d cycles", cur_test, cycle_cnt);
         $display("TEST FAIL");
         $fatal(1, "simulation timeout");
      end
   end

   initial begin
      row_t r;
      int   target;
      void'($urandom(32'h152ff944));
      for (int p = 0; p < NUM_PLAYERS; p++) begin
         player_move[p] = '0;
         sprite_num[p]  = sprite_num_t'(p);
      end
      add_row("hold_start",   4'b0000, 4'b0000, 3'd0, 3'd1, 2,  4,  4,  6,  6);
      add_row("recolour",     4'b0000, 4'b0000, 3'd3, 3'd5, 1,  4,  4,  6,  6);
      add_row("p0_right",     4'b0001, 4'b0000, 3'd0, 3'd1, 3,  10, 4,  6,  6);
      add_row("p1_down",      4'b0000, 4'b0100, 3'd2, 3'd6, 2,  10, 4,  6,  10);
      add_row("opposed",      4'b0011, 4'b1100, 3'd4, 3'd7, 2,  10, 4,  6,  10);
      add_row("p0_up_clamp",  4'b1000, 4'b0000, 3'd0, 3'd1, 4,  10, 0,  6,  10);
      add_row("clamp_corner", 4'b0100, 4'b0001, 3'd1, 3'd2, 15, 10, 20, 28, 10);
      add_row("diagonal",     4'b1001, 4'b0110, 3'd5, 3'd3, 5,  20, 10, 18, 20);
      timeout_limit = RESET_CYCLES + ((total_frames + 2) * FRAME_CYCLES * 12) / 10;
      @(negedge clock_50);
      check_reset_outputs();
      while (!rst_n) @(negedge clock_50);
      @(negedge clock_50);                      // after first edge out of reset
      cur_test = "first_edge";
      check_reset_outputs();
      target = 1;
      wait_vs_falls(target);                    // rows start inside vertical blanking
      foreach (rows[i]) begin
         r = rows[i];
         if ($urandom % 4 == 0) begin
            r.num[0] = sprite_num_t'($urandom % 8);
            r.num[1] = sprite_num_t'($urandom % 8);
         end
         #DRIVE_DELAY;
         cur_test = names[i];
         for (int p = 0; p < NUM_PLAYERS; p++) begin
            player_move[p] = r.mv[p];
            sprite_num[p]  = r.num[p];
         end
         target += r.frames;
         wait_vs_falls(target);
         for (int p = 0; p < NUM_PLAYERS; p++) begin
            check_coord($sformatf("pos%0d_x", p), r.exp_pos[p].x, pos_model[p].x);
            check_coord($sformatf("pos%0d_y", p), r.exp_pos[p].y, pos_model[p].y);
         end
      end
      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire
